//--- rtl/dmm_ctl_pkg.sv
/*
  dmm control core shared definitions
  widths, vector types, bit positions in the conditioning vector,
  host register numbers and the output mode codes
*/

`default_nettype none

package dmm_ctl_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and vector types

  localparam int COND_BITS = 29;                  // 4x4 mux + 8 mon + 5 singles

  typedef logic [COND_BITS-1:0] cond_vec_t;       // full conditioning output
  typedef logic [31:0]          reg_word_t;       // host register word
  typedef logic [7:0]           reg_addr_t;       // bit 7 read flag, 6..0 register
  typedef logic [3:0]           mux_ctl_t;        // {en, a2, a1, a0}
  typedef logic [7:0]           monitor_t;        // mon7..mon0

  // output mode codes, 4, 6 and 7 fall through to zeros
  typedef enum logic [2:0] {
    MODE_LED     = 3'd0,    // mcu owns the led only
    MODE_ONES    = 3'd1,
    MODE_PATTERN = 3'd2,    // free running counter
    MODE_DIRECT  = 3'd3,    // register image straight to pins
    MODE_AZ      = 3'd5     // auto-zero sequencer
  } mode_t;

  //////////////////////////////////////////////////////////////////////
  // bit positions in cond_vec_t, lsb of each field

  localparam int IDX_AZMUX         = 0;     // 0..3
  localparam int IDX_HIMUX         = 4;     // 4..7
  localparam int IDX_HIMUX2        = 8;     // 8..11
  localparam int IDX_SIG_PC_SW     = 12;
  localparam int IDX_LED0          = 13;
  localparam int IDX_MONITOR       = 14;    // 14..21
  localparam int IDX_ADCMUX        = 22;    // 22..25
  localparam int IDX_CMPR_LATCH    = 26;
  localparam int IDX_MEAS_COMPLETE = 27;
  localparam int IDX_SPI_INTERRUPT = 28;

  // register numbers, low seven bits of the address byte
  localparam logic [6:0] ADDR_LED             = 7'd7;
  localparam logic [6:0] ADDR_MODE            = 7'd8;
  localparam logic [6:0] ADDR_DIRECT          = 7'd9;
  localparam logic [6:0] ADDR_SAMPLE_DURATION = 7'd10;

  // azmux enabled on channel 0, the pre-charged signal path
  localparam mux_ctl_t AZMUX_PC = 4'b1000;

  // shortest phase the modulator will run, in clk cycles
  localparam int MIN_SAMPLE_DURATION = 2;

endpackage

`default_nettype wire

//--- rtl/spi_register_bank.sv
/*
  spi register bank
  oversamples the host spi pins in the clk domain, shifts 40 bit frames
  (address byte then data word) and holds the four host registers
*/

`default_nettype none

module spi_register_bank #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   spi_clk,
  input  logic                   spi_cs,     // active low
  input  logic                   spi_mosi,
  output logic                   spi_miso,
  output dmm_ctl_pkg::reg_word_t reg_led,
  output dmm_ctl_pkg::reg_word_t reg_mode,
  output dmm_ctl_pkg::reg_word_t reg_direct,
  output dmm_ctl_pkg::reg_word_t reg_sample_duration
);
  import dmm_ctl_pkg::*;

  localparam logic [5:0] FRAME_BITS = 6'd40;
  localparam logic [5:0] ADDR_BITS  = 6'd8;

  logic [SYNC_STAGES-1:0] sclk_sync;
  logic [SYNC_STAGES-1:0] cs_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic      sclk_s, cs_s, mosi_s;        // synchronized pins
  logic      sclk_d, cs_d;                // one cycle behind for edge detect
  logic      sclk_rise, sclk_fall, cs_rise;
  logic      selected;

  logic [5:0] bit_cnt;                    // bits seen in this frame
  logic       overrun;                    // set past 40 clocks to drop the frame
  reg_word_t  rx_q;                       // incoming shift register
  reg_addr_t  addr_q;                     // latched address byte
  reg_addr_t  next_addr;
  reg_word_t  read_word;
  reg_word_t  tx_q;                       // outgoing shift register
  logic       miso_q;
  logic       write_en;

  //////////////////////////////////////////////////////////////////////
  // pin synchronizers and edge detect

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sclk_sync <= '0;
      cs_sync   <= '1;                    // come up deselected
      mosi_sync <= '0;
      sclk_d    <= 1'b0;
      cs_d      <= 1'b1;
    end
    else
    begin
      sclk_sync[0] <= spi_clk;
      cs_sync[0]   <= spi_cs;
      mosi_sync[0] <= spi_mosi;
      for (int i = 1; i < SYNC_STAGES; i++)
      begin
        sclk_sync[i] <= sclk_sync[i-1];
        cs_sync[i]   <= cs_sync[i-1];
        mosi_sync[i] <= mosi_sync[i-1];
      end
      sclk_d <= sclk_s;
      cs_d   <= cs_s;
    end
  end

  assign sclk_s    = sclk_sync[SYNC_STAGES-1];
  assign cs_s      = cs_sync[SYNC_STAGES-1];
  assign mosi_s    = mosi_sync[SYNC_STAGES-1];
  assign sclk_rise = sclk_s & ~sclk_d;    // mosi sample point
  assign sclk_fall = ~sclk_s & sclk_d;    // miso launch point
  assign cs_rise   = cs_s & ~cs_d;        // end of frame
  assign selected  = ~cs_s;

  //////////////////////////////////////////////////////////////////////
  // frame shifter

  always_ff @(posedge clk)
  begin
    if (reset || !selected)
    begin
      bit_cnt <= '0;
      overrun <= 1'b0;
    end
    else if (sclk_rise)
    begin
      if (bit_cnt == FRAME_BITS)
        overrun <= 1'b1;                  // hold count and mark frame bad
      else
        bit_cnt <= bit_cnt + 6'd1;
    end
  end

  assign next_addr = {rx_q[6:0], mosi_s}; // address byte as its last bit lands

  always_ff @(posedge clk)
  begin
    if (selected && sclk_rise && bit_cnt != FRAME_BITS)
    begin
      rx_q <= {rx_q[30:0], mosi_s};
      if (bit_cnt == ADDR_BITS - 6'd1)
        addr_q <= next_addr;
    end
  end

  // readback source where unknown numbers give zero
  always_comb
  begin
    case (next_addr[6:0])
      ADDR_LED:             read_word = reg_led;
      ADDR_MODE:            read_word = reg_mode;
      ADDR_DIRECT:          read_word = reg_direct;
      ADDR_SAMPLE_DURATION: read_word = reg_sample_duration;
      default:              read_word = '0;
    endcase
  end

  // snapshot at end of address byte then shift msb first on falling edges
  always_ff @(posedge clk)
  begin
    if (selected && sclk_rise && bit_cnt == ADDR_BITS - 6'd1)
      tx_q <= read_word;
    else if (selected && sclk_fall && bit_cnt >= ADDR_BITS && bit_cnt < FRAME_BITS)
      tx_q <= {tx_q[30:0], 1'b0};
  end

  always_ff @(posedge clk)
  begin
    if (reset || !selected)
      miso_q <= 1'b0;                     // low whenever deselected
    else if (sclk_fall)
      miso_q <= (bit_cnt >= ADDR_BITS && bit_cnt < FRAME_BITS) ? tx_q[31] : 1'b0;
  end

  assign spi_miso = miso_q;

  //////////////////////////////////////////////////////////////////////
  // host registers

  // only a clean 40 bit write frame commits
  assign write_en = cs_rise && bit_cnt == FRAME_BITS && !overrun && !addr_q[7];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      reg_led             <= '0;
      reg_mode            <= '0;
      reg_direct          <= '0;
      reg_sample_duration <= '0;
    end
    else if (write_en)
    begin
      case (addr_q[6:0])
        ADDR_LED:             reg_led             <= rx_q;
        ADDR_MODE:            reg_mode            <= rx_q;
        ADDR_DIRECT:          reg_direct          <= rx_q;
        ADDR_SAMPLE_DURATION: reg_sample_duration <= rx_q;
        default:              ;               // unknown number is ignored
      endcase
    end
  end

  a_bit_cnt_bound: assert property (@(posedge clk) disable iff (reset)
    selected |-> bit_cnt <= FRAME_BITS);

  // registers hold while the host has the chip selected
  a_regs_stable_in_frame: assert property (@(posedge clk) disable iff (reset)
    !spi_cs |=> $stable({reg_led, reg_mode, reg_direct, reg_sample_duration}));

endmodule

`default_nettype wire

//--- rtl/az_modulator.sv
/*
  auto-zero modulator
  alternates a signal phase (pre-charge switch on, azmux on the
  pre-charged path) and a lo phase (azmux from the direct register),
  flagging the end of every lo phase as a finished measurement
*/

`default_nettype none

module az_modulator #(
  parameter int MODULATOR_COUNT_BITS = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  dmm_ctl_pkg::mux_ctl_t  azmux_lo_val,      // azmux code for lo phase
  input  dmm_ctl_pkg::reg_word_t sample_duration,   // clk cycles per phase
  output logic                   sig_pc_sw_ctl,
  output logic                   led0,
  output logic                   meas_complete,
  output dmm_ctl_pkg::mux_ctl_t  azmux,
  output dmm_ctl_pkg::monitor_t  monitor
);
  import dmm_ctl_pkg::*;

  typedef logic [MODULATOR_COUNT_BITS-1:0] count_t;

  typedef enum logic {
    SIG,                  // sampling the pre-charged signal
    LO                    // sampling lo through azmux
  } phase_t;

  phase_t state;
  count_t phase_cnt;      // cycles into the current phase
  count_t dur_q;          // length of the current phase
  count_t dur_raw;
  count_t dur_next;
  logic   phase_last;
  logic   led_q;

  //////////////////////////////////////////////////////////////////////
  // phase length, clamped to the minimum

  assign dur_raw  = count_t'(sample_duration);
  assign dur_next = (dur_raw < count_t'(MIN_SAMPLE_DURATION))
                  ? count_t'(MIN_SAMPLE_DURATION)
                  : dur_raw;

  assign phase_last = (phase_cnt == dur_q - count_t'(1));

  //////////////////////////////////////////////////////////////////////
  // phase sequencer

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= SIG;
      phase_cnt <= '0;
      dur_q     <= count_t'(MIN_SAMPLE_DURATION);
    end
    else if (phase_last)
    begin
      state     <= (state == SIG) ? LO : SIG;   // no gap between phases
      phase_cnt <= '0;
      dur_q     <= dur_next;                    // new length each phase
    end
    else
    begin
      phase_cnt <= phase_cnt + count_t'(1);
    end
  end

  // led flips once per measurement, visual heartbeat
  always_ff @(posedge clk)
  begin
    if (reset)
      led_q <= 1'b0;
    else if (meas_complete)
      led_q <= ~led_q;
  end

  //////////////////////////////////////////////////////////////////////
  // outputs, decoded from the phase

  assign sig_pc_sw_ctl = (state == SIG);
  assign azmux         = (state == SIG) ? AZMUX_PC : azmux_lo_val;
  assign meas_complete = (state == LO) && phase_last;  // last lo cycle
  assign led0          = led_q;

  // mon0 phase, mon1 measurement strobe, rest spare
  assign monitor = {6'b000000, meas_complete, (state == LO)};

  a_phase_cnt_bound: assert property (@(posedge clk) disable iff (reset)
    phase_cnt < dur_q);

endmodule

`default_nettype wire

//--- rtl/mode_select.sv
/*
  output mode selector
  builds the auto-zero conditioning vector, runs the test pattern counter
  and registers the source picked by the mode onto the board pins
*/

`default_nettype none

module mode_select (
  input  logic                   clk,
  input  logic                   reset,
  input  dmm_ctl_pkg::mode_t     mode,
  input  dmm_ctl_pkg::reg_word_t reg_led,
  input  dmm_ctl_pkg::reg_word_t reg_direct,
  input  logic                   az_sig_pc_sw_ctl,
  input  logic                   az_led0,
  input  logic                   az_meas_complete,
  input  dmm_ctl_pkg::mux_ctl_t  az_azmux,
  input  dmm_ctl_pkg::monitor_t  az_monitor,
  output dmm_ctl_pkg::mux_ctl_t  azmux,
  output dmm_ctl_pkg::mux_ctl_t  himux,
  output dmm_ctl_pkg::mux_ctl_t  himux2,
  output dmm_ctl_pkg::mux_ctl_t  adcmux,
  output logic                   sig_pc_sw_ctl,
  output logic                   led0,
  output logic                   cmpr_latch_ctl,
  output logic                   meas_complete_ctl,
  output logic                   spi_interrupt_ctl,
  output dmm_ctl_pkg::monitor_t  monitor
);
  import dmm_ctl_pkg::*;

  cond_vec_t pattern_q;   // test pattern, walks every pin
  cond_vec_t led_vec;
  cond_vec_t az_vec;
  cond_vec_t cond_q;      // registered pin image

  always_ff @(posedge clk)
  begin
    if (reset)
      pattern_q <= '0;
    else
      pattern_q <= pattern_q + 1'b1;      // wraps mod 2^29
  end

  // mcu led only, everything else parked low
  always_comb
  begin
    led_vec           = '0;
    led_vec[IDX_LED0] = reg_led[0];
  end

  // modulator drives switching, himux/adcmux/latch/irq pass from direct
  assign az_vec[IDX_AZMUX +: 4]       = az_azmux;
  assign az_vec[IDX_HIMUX +: 4]       = reg_direct[IDX_HIMUX +: 4];
  assign az_vec[IDX_HIMUX2 +: 4]      = reg_direct[IDX_HIMUX2 +: 4];
  assign az_vec[IDX_SIG_PC_SW]        = az_sig_pc_sw_ctl;
  assign az_vec[IDX_LED0]             = az_led0;
  assign az_vec[IDX_MONITOR +: 8]     = az_monitor;
  assign az_vec[IDX_ADCMUX +: 4]      = reg_direct[IDX_ADCMUX +: 4];
  assign az_vec[IDX_CMPR_LATCH]       = reg_direct[IDX_CMPR_LATCH];
  assign az_vec[IDX_MEAS_COMPLETE]    = az_meas_complete;
  assign az_vec[IDX_SPI_INTERRUPT]    = reg_direct[IDX_SPI_INTERRUPT];

  ////////////////////////////////////////////////////////////////////////
  // 8-way select, one register stage to the pins

  always_ff @(posedge clk)
  begin
    if (reset)
      cond_q <= '0;
    else
    begin
      case (mode)
        MODE_LED:     cond_q <= led_vec;
        MODE_ONES:    cond_q <= '1;
        MODE_PATTERN: cond_q <= pattern_q;
        MODE_DIRECT:  cond_q <= reg_direct[COND_BITS-1:0];
        MODE_AZ:      cond_q <= az_vec;
        default:      cond_q <= '0;       // 4, 6, 7 unused
      endcase
    end
  end

  assign azmux             = cond_q[IDX_AZMUX +: 4];
  assign himux             = cond_q[IDX_HIMUX +: 4];
  assign himux2            = cond_q[IDX_HIMUX2 +: 4];
  assign sig_pc_sw_ctl     = cond_q[IDX_SIG_PC_SW];
  assign led0              = cond_q[IDX_LED0];
  assign monitor           = cond_q[IDX_MONITOR +: 8];
  assign adcmux            = cond_q[IDX_ADCMUX +: 4];
  assign cmpr_latch_ctl    = cond_q[IDX_CMPR_LATCH];
  assign meas_complete_ctl = cond_q[IDX_MEAS_COMPLETE];
  assign spi_interrupt_ctl = cond_q[IDX_SPI_INTERRUPT];

endmodule

`default_nettype wire

//--- rtl/dmm_ctl_top.sv
/*
  dmm control core top level
  host spi register bank, auto-zero modulator and output mode selector
*/

`default_nettype none

module dmm_ctl_top (
  input  logic                  clk,
  input  logic                  reset,
  // host spi
  input  logic                  spi_clk,
  input  logic                  spi_cs,            // active low
  input  logic                  spi_mosi,
  output logic                  spi_miso,
  // analog conditioning
  output dmm_ctl_pkg::mux_ctl_t azmux,             // u414
  output dmm_ctl_pkg::mux_ctl_t himux,             // u413
  output dmm_ctl_pkg::mux_ctl_t himux2,            // u402
  output dmm_ctl_pkg::mux_ctl_t adcmux,            // u902 current switches
  output logic                  sig_pc_sw_ctl,
  output logic                  led0,
  output dmm_ctl_pkg::monitor_t monitor,
  output logic                  cmpr_latch_ctl,
  output logic                  meas_complete_ctl,
  output logic                  spi_interrupt_ctl
);
  import dmm_ctl_pkg::*;

  reg_word_t reg_led;
  reg_word_t reg_mode;                             // only 2..0 used
  reg_word_t reg_direct;
  reg_word_t reg_sample_duration;

  logic      az_sig_pc_sw_ctl;
  logic      az_led0;
  logic      az_meas_complete;
  mux_ctl_t  az_azmux;
  monitor_t  az_monitor;

  spi_register_bank #(
    .SYNC_STAGES (2)
  ) u_spi_register_bank (
    .clk                 (clk),
    .reset               (reset),
    .spi_clk             (spi_clk),
    .spi_cs              (spi_cs),
    .spi_mosi            (spi_mosi),
    .spi_miso            (spi_miso),
    .reg_led             (reg_led),
    .reg_mode            (reg_mode),
    .reg_direct          (reg_direct),
    .reg_sample_duration (reg_sample_duration)
  );

  az_modulator #(
    .MODULATOR_COUNT_BITS (32)
  ) u_az_modulator (
    .clk             (clk),
    .reset           (reset),
    .azmux_lo_val    (reg_direct[IDX_AZMUX +: 4]),   // lo path chosen by host
    .sample_duration (reg_sample_duration),
    .sig_pc_sw_ctl   (az_sig_pc_sw_ctl),
    .led0            (az_led0),
    .meas_complete   (az_meas_complete),
    .azmux           (az_azmux),
    .monitor         (az_monitor)
  );

  mode_select u_mode_select (
    .clk               (clk),
    .reset             (reset),
    .mode              (mode_t'(reg_mode[2:0])),
    .reg_led           (reg_led),
    .reg_direct        (reg_direct),
    .az_sig_pc_sw_ctl  (az_sig_pc_sw_ctl),
    .az_led0           (az_led0),
    .az_meas_complete  (az_meas_complete),
    .az_azmux          (az_azmux),
    .az_monitor        (az_monitor),
    .azmux             (azmux),
    .himux             (himux),
    .himux2            (himux2),
    .adcmux            (adcmux),
    .sig_pc_sw_ctl     (sig_pc_sw_ctl),
    .led0              (led0),
    .cmpr_latch_ctl    (cmpr_latch_ctl),
    .meas_complete_ctl (meas_complete_ctl),
    .spi_interrupt_ctl (spi_interrupt_ctl),
    .monitor           (monitor)
  );

endmodule

`default_nettype wire

//--- include/tb_spi_tasks.svh
/*
  testbench host spi tasks
  40 bit frames (address byte then data word), msb first,
  plus the value compare used by every check
*/

`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// one mismatch gives one FAIL line
task automatic compare_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
  check_count++;
  if (got !== expected)
  begin
    error_count++;
    $display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, expected);
  end
endtask

// full or cut short frame, data bits read back from miso
task automatic spi_frame(input logic [7:0] addr_byte, input logic [31:0] data,
                         input int nbits, output logic [31:0] rdata);
  logic [39:0] frame;
  frame = {addr_byte, data};
  rdata = '0;
  @(negedge clk);
  spi_cs = 1'b0;
  repeat (SPI_HALF) @(negedge clk);
  for (int k = 0; k < nbits; k++)
  begin
    spi_clk  = 1'b0;
    spi_mosi = frame[39-k];
    repeat (SPI_HALF) @(negedge clk);
    if (k >= 8)
      rdata = {rdata[30:0], spi_miso};     // launched on the previous fall
    spi_clk = 1'b1;                        // slave samples mosi here
    repeat (SPI_HALF) @(negedge clk);
  end
  spi_clk = 1'b0;
  repeat (SPI_HALF) @(negedge clk);
  spi_cs   = 1'b1;                         // commit point for writes
  spi_mosi = 1'b0;
  repeat (SPI_HALF) @(negedge clk);
endtask

task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
  logic [31:0] unused;
  spi_frame({1'b0, addr}, data, 40, unused);
endtask

task automatic read_reg(input logic [6:0] addr, output logic [31:0] data);
  spi_frame({1'b1, addr}, 32'h0, 40, data);
endtask

// frame dropped after 20 bits, must not commit
task automatic short_write(input logic [6:0] addr, input logic [31:0] data);
  logic [31:0] unused;
  spi_frame({1'b0, addr}, data, 20, unused);
endtask

`endif

//--- tb/tb_dmm_ctl.sv
/*
  testbench for the dmm control core
  runs host spi frames from a pattern file, keeps its own register image
  and checks the board pins in every output mode
*/

`default_nettype none

module tb_dmm_ctl;
  import dmm_ctl_pkg::*;

  localparam int SPI_HALF      = 6;       // clk cycles per spi_clk level
  localparam int CYCLES_PER_OP = 600;
  localparam int CYCLES_MARGIN = 5000;

  logic      clk;
  logic      reset;
  logic      spi_clk;
  logic      spi_cs;
  logic      spi_mosi;
  logic      spi_miso;
  mux_ctl_t  azmux;
  mux_ctl_t  himux;
  mux_ctl_t  himux2;
  mux_ctl_t  adcmux;
  logic      sig_pc_sw_ctl;
  logic      led0;
  monitor_t  monitor;
  logic      cmpr_latch_ctl;
  logic      meas_complete_ctl;
  logic      spi_interrupt_ctl;

  int        error_count = 0;
  int        check_count = 0;
  integer    seed;
  reg_word_t last_random;                 // most recent drawn data word
  reg_word_t exp_led;                     // expected register image
  reg_word_t exp_mode;
  reg_word_t exp_direct;
  reg_word_t exp_dur;

  string       op_q[$];                   // pattern lines
  logic [7:0]  addr_q[$];
  string       val_q[$];
  logic        patterns_loaded = 1'b0;

  `include "tb_spi_tasks.svh"

  dmm_ctl_top u_dmm_ctl_top (
    .clk               (clk),
    .reset             (reset),
    .spi_clk           (spi_clk),
    .spi_cs            (spi_cs),
    .spi_mosi          (spi_mosi),
    .spi_miso          (spi_miso),
    .azmux             (azmux),
    .himux             (himux),
    .himux2            (himux2),
    .adcmux            (adcmux),
    .sig_pc_sw_ctl     (sig_pc_sw_ctl),
    .led0              (led0),
    .monitor           (monitor),
    .cmpr_latch_ctl    (cmpr_latch_ctl),
    .meas_complete_ctl (meas_complete_ctl),
    .spi_interrupt_ctl (spi_interrupt_ctl)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;                // period 8
  end

  //////////////////////////////////////////////////////////////////////
  // pin image and expected vectors

  // board pins back into one vector in package bit order
  function automatic cond_vec_t pin_vector();
    cond_vec_t v;
    v[IDX_AZMUX +: 4]       = azmux;
    v[IDX_HIMUX +: 4]       = himux;
    v[IDX_HIMUX2 +: 4]      = himux2;
    v[IDX_SIG_PC_SW]        = sig_pc_sw_ctl;
    v[IDX_LED0]             = led0;
    v[IDX_MONITOR +: 8]     = monitor;
    v[IDX_ADCMUX +: 4]      = adcmux;
    v[IDX_CMPR_LATCH]       = cmpr_latch_ctl;
    v[IDX_MEAS_COMPLETE]    = meas_complete_ctl;
    v[IDX_SPI_INTERRUPT]    = spi_interrupt_ctl;
    return v;
  endfunction

  function automatic cond_vec_t static_expect(input logic [2:0] code);
    cond_vec_t v;
    v = '0;                               // 4, 6, 7 stay all zeros
    case (code)
      MODE_LED:    v[IDX_LED0] = exp_led[0];
      MODE_ONES:   v = '1;
      MODE_DIRECT: v = exp_direct[COND_BITS-1:0];
      default:     v = '0;
    endcase
    return v;
  endfunction

  task automatic model_write(input logic [6:0] addr, input reg_word_t data);
    case (addr)
      ADDR_LED:             exp_led    = data;
      ADDR_MODE:            exp_mode   = data;
      ADDR_DIRECT:          exp_direct = data;
      ADDR_SAMPLE_DURATION: exp_dur    = data;
      default:              ;             // unknown number has no register
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // mode checks on pins sampled at the falling edge

  task automatic verify_static(input logic [2:0] code, input int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      compare_value($sformatf("mode %0d pins", code), pin_vector(), static_expect(code));
    end
  endtask

  task automatic verify_pattern(input int cycles);
    cond_vec_t prev;
    cond_vec_t cur;
    @(negedge clk);
    prev = pin_vector();
    repeat (cycles)
    begin
      @(negedge clk);
      cur = pin_vector();
      compare_value("pattern step", cur, cond_vec_t'(prev + 1));   // 29 bit wrap
      prev = cur;
    end
  endtask

  task automatic verify_az(input int cycles);
    reg_word_t d;
    int        run_len;
    int        runs_checked;
    int        pulses;
    logic      seen_edge;
    logic      sig;
    logic      meas;
    logic      prev_sig;
    logic      prev_meas;
    logic      prev_led;
    d            = (exp_dur < MIN_SAMPLE_DURATION) ? MIN_SAMPLE_DURATION : exp_dur;
    run_len      = 0;
    runs_checked = 0;
    pulses       = 0;
    seen_edge    = 1'b0;
    for (int n = 0; n < cycles; n++)
    begin
      @(negedge clk);
      sig  = sig_pc_sw_ctl;
      meas = meas_complete_ctl;
      compare_value("az azmux", azmux, sig ? AZMUX_PC : exp_direct[IDX_AZMUX +: 4]);
      compare_value("az himux", himux, exp_direct[IDX_HIMUX +: 4]);
      compare_value("az himux2", himux2, exp_direct[IDX_HIMUX2 +: 4]);
      compare_value("az adcmux", adcmux, exp_direct[IDX_ADCMUX +: 4]);
      compare_value("az cmpr_latch", cmpr_latch_ctl, exp_direct[IDX_CMPR_LATCH]);
      compare_value("az spi_interrupt", spi_interrupt_ctl, exp_direct[IDX_SPI_INTERRUPT]);
      compare_value("az monitor", monitor, {6'b000000, meas, ~sig});
      if (n > 0)
      begin
        // pulse only on the last lo cycle
        compare_value("az meas_complete", prev_meas, !prev_sig && sig);
        compare_value("az led0", led0, prev_led ^ prev_meas);
        if (prev_meas)
          pulses++;
        if (sig != prev_sig)
        begin
          if (seen_edge)                  // first run is partial
          begin
            compare_value("az run length", run_len, d);
            runs_checked++;
          end
          seen_edge = 1'b1;
          run_len   = 1;
        end
        else
          run_len++;
      end
      else
        run_len = 1;
      prev_sig  = sig;
      prev_meas = meas;
      prev_led  = led0;
    end
    if (runs_checked < 2 || pulses == 0)
    begin
      error_count++;
      $display("auto-zero check saw too few phase changes or no measurement pulse");
    end
  endtask

  task automatic run_mode_check(input logic [2:0] code, input int cycles);
    write_reg(ADDR_MODE, {29'd0, code});
    model_write(ADDR_MODE, {29'd0, code});
    repeat (4) @(negedge clk);
    case (exp_mode[2:0])
      MODE_PATTERN: verify_pattern(cycles);
      MODE_AZ:      verify_az(cycles);
      default:      verify_static(exp_mode[2:0], cycles);
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // pattern file

  task automatic load_patterns();
    int         fd;
    int         n;
    string      line;
    string      op_s;
    string      val_s;
    logic [7:0] addr;
    fd = $fopen("tb/dmm_ctl_patterns.txt", "r");
    if (fd == 0)
    begin
      error_count++;
      $display("could not open pattern file tb/dmm_ctl_patterns.txt");
    end
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        n = $sscanf(line, "%s %h %s", op_s, addr, val_s);
        if (n == 3 && op_s[0] != "#")
        begin
          op_q.push_back(op_s);
          addr_q.push_back(addr);
          val_q.push_back(val_s);
        end
        else if (n >= 1 && op_s[0] != "#")
        begin
          error_count++;
          $display("malformed pattern line: %s", line);
        end
      end
      $fclose(fd);
    end
    patterns_loaded = 1'b1;
  endtask

  task automatic run_patterns();
    reg_word_t value;
    reg_word_t rdata;
    for (int i = 0; i < op_q.size(); i++)
    begin
      if (val_q[i] == "random")
      begin
        if (op_q[i] == "W")
          last_random = $random(seed);    // fresh word for each write
        value = last_random;
      end
      else
        void'($sscanf(val_q[i], "%h", value));
      if (op_q[i] == "W")
      begin
        write_reg(addr_q[i][6:0], value);
        model_write(addr_q[i][6:0], value);
      end
      else if (op_q[i] == "S")
        short_write(addr_q[i][6:0], value);
      else if (op_q[i] == "R")
      begin
        read_reg(addr_q[i][6:0], rdata);
        compare_value($sformatf("read of register %0d", addr_q[i][6:0]), rdata, value);
      end
      else if (op_q[i] == "O")
        run_mode_check(addr_q[i][2:0], value);
      else
      begin
        error_count++;
        $display("unknown operation %s in pattern line %0d", op_q[i], i);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial
  begin
    seed        = 32'h9da;
    last_random = '0;
    exp_led     = '0;
    exp_mode    = '0;
    exp_direct  = '0;
    exp_dur     = '0;
    reset       = 1'b1;
    spi_clk     = 1'b0;
    spi_cs      = 1'b1;
    spi_mosi    = 1'b0;
    load_patterns();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);
    compare_value("pins after reset", pin_vector(), '0);
    compare_value("miso after reset", spi_miso, 1'b0);
    run_patterns();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    wait (patterns_loaded);
    repeat (op_q.size() * CYCLES_PER_OP + CYCLES_MARGIN) @(posedge clk);
    $display("timeout, the pattern run did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
rtl/dmm_ctl_pkg.sv
rtl/spi_register_bank.sv
rtl/az_modulator.sv
rtl/mode_select.sv
rtl/dmm_ctl_top.sv
tb/tb_dmm_ctl.sv

//--- Bender.yml
package:
  name: dmm_ctl

sources:
  - files:
      - rtl/dmm_ctl_pkg.sv
      - rtl/spi_register_bank.sv
      - rtl/az_modulator.sv
      - rtl/mode_select.sv
      - rtl/dmm_ctl_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_dmm_ctl.sv

//--- tb/dmm_ctl_patterns.txt
# columns: op addr value, addr and value in hex, random draws a data word
# W write, S write cut at 20 bits, R read and compare, O mode in addr, cycles in value
R 07 00000000
R 08 00000000
R 09 00000000
R 0a 00000000
W 07 a5a5a5a5
R 07 a5a5a5a5
W 09 random
R 09 random
W 0a 00000014
R 0a 00000014
W 08 00000003
R 08 00000003
W 0c deadbeef
R 0c 00000000
S 07 00000000
R 07 a5a5a5a5
O 0 10
O 1 10
O 3 10
O 4 8
O 6 8
O 7 8
O 2 40
O 5 c8
W 0a 00000000
O 5 28
W 07 00000000
O 0 10
